// ==== common/cache_cfg_pkg.sv ====
package cache_cfg_pkg;

    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;
    localparam int MASK_W = WORD_W / 8;            // one bit per byte lane
    localparam int LINE_W = 256;
    localparam int BEAT_W = 64;                    // bmem burst width

    localparam int WORDS_PER_LINE = LINE_W / WORD_W;
    localparam int BEATS_PER_LINE = LINE_W / BEAT_W;

    localparam int NUM_SETS = 16;                  // direct-mapped, one line per set

    // address split: tag | index | byte offset
    localparam int OFFSET_W   = $clog2(LINE_W / 8);
    localparam int WORD_SEL_W = $clog2(WORDS_PER_LINE);
    localparam int INDEX_W    = $clog2(NUM_SETS);
    localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;

endpackage : cache_cfg_pkg

// ==== common/mem_types_pkg.sv ====
package mem_types_pkg;

    import cache_cfg_pkg::*;

    // one line, seen as cpu words by the caches and as bursts by the adaptor
    typedef union packed {
        logic [WORDS_PER_LINE-1:0][WORD_W-1:0] words;
        logic [BEATS_PER_LINE-1:0][BEAT_W-1:0] beats;
    } cache_line_u;

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } addr_fields_t;

    // cpu side word port
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              read;
        logic              write;
        logic [MASK_W-1:0] wmask;
        logic [WORD_W-1:0] wdata;
    } word_req_t;

    typedef struct packed {
        logic [WORD_W-1:0] rdata;
        logic              resp;
    } word_rsp_t;

    // line port between caches, arbiter and adaptor
    typedef struct packed {
        logic [ADDR_W-1:0] addr;                   // line aligned
        logic              read;
        logic              write;
        cache_line_u       wdata;
    } line_req_t;

    typedef struct packed {
        cache_line_u rdata;
        logic        resp;
    } line_rsp_t;

endpackage : mem_types_pkg

// ==== dcache/dcache.sv ====
module dcache
    import cache_cfg_pkg::*;
    import mem_types_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  word_req_t req_i,
    output word_rsp_t rsp_o,
    output line_req_t line_req_o,
    input  line_rsp_t line_rsp_i
);

    typedef enum logic [1:0] {
        ST_COMPARE,
        ST_WRITEBACK,
        ST_FILL
    } state_e;

    state_e state_q;

    logic [TAG_W-1:0]    tag_arr [NUM_SETS];
    cache_line_u         data_arr [NUM_SETS];
    logic [NUM_SETS-1:0] valid_q;
    logic [NUM_SETS-1:0] dirty_q;

    addr_fields_t          fields;
    logic [WORD_SEL_W-1:0] word_sel;
    logic [TAG_W-1:0]      victim_tag;
    logic                  hit;
    logic                  req_new;
    logic                  resp_q;
    logic [WORD_W-1:0]     rdata_q;

    assign fields     = addr_fields_t'(req_i.addr);
    assign word_sel   = fields.offset[OFFSET_W-1 -: WORD_SEL_W];
    assign victim_tag = tag_arr[fields.index];
    assign hit        = valid_q[fields.index] && (victim_tag == fields.tag);
    assign req_new    = (req_i.read || req_i.write) && !resp_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_COMPARE;
            valid_q <= '0;
            dirty_q <= '0;
            resp_q  <= 1'b0;
        end else begin
            resp_q <= 1'b0;
            case (state_q)
                ST_COMPARE: begin
                    if (req_new && hit) begin
                        resp_q <= 1'b1;
                        if (req_i.write) begin
                            dirty_q[fields.index] <= 1'b1;
                        end
                    end else if (req_new && valid_q[fields.index] && dirty_q[fields.index]) begin
                        state_q <= ST_WRITEBACK;   // victim goes out first
                    end else if (req_new) begin
                        state_q <= ST_FILL;
                    end
                end
                ST_WRITEBACK: begin
                    if (line_rsp_i.resp) begin
                        state_q <= ST_FILL;
                    end
                end
                ST_FILL: begin
                    if (line_rsp_i.resp) begin
                        valid_q[fields.index] <= 1'b1;
                        dirty_q[fields.index] <= 1'b0;
                        state_q <= ST_COMPARE;
                    end
                end
                default: state_q <= ST_COMPARE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_FILL && line_rsp_i.resp) begin
            tag_arr[fields.index]  <= fields.tag;
            data_arr[fields.index] <= line_rsp_i.rdata;
        end
        if (state_q == ST_COMPARE && hit) begin
            rdata_q <= data_arr[fields.index].words[word_sel];
        end
        // byte merge on a write hit
        if (state_q == ST_COMPARE && req_new && hit && req_i.write) begin
            for (int b = 0; b < MASK_W; b++) begin
                if (req_i.wmask[b]) begin
                    data_arr[fields.index].words[word_sel][8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    assign rsp_o.rdata = rdata_q;
    assign rsp_o.resp  = resp_q;

    always_comb begin
        line_req_o.read  = (state_q == ST_FILL);
        line_req_o.write = (state_q == ST_WRITEBACK);
        line_req_o.wdata = data_arr[fields.index];
        if (state_q == ST_WRITEBACK) begin
            line_req_o.addr = {victim_tag, fields.index, {OFFSET_W{1'b0}}};
        end else begin
            line_req_o.addr = {fields.tag, fields.index, {OFFSET_W{1'b0}}};
        end
    end

endmodule : dcache

// ==== hdl/cacheline_adaptor.sv ====
module cacheline_adaptor
    import cache_cfg_pkg::*;
    import mem_types_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  line_req_t         req_i,
    output line_rsp_t         rsp_o,
    output logic [ADDR_W-1:0] bmem_address_o,
    output logic              bmem_read_o,
    output logic              bmem_write_o,
    output logic [BEAT_W-1:0] bmem_wdata_o,
    input  logic [BEAT_W-1:0] bmem_rdata_i,
    input  logic              bmem_resp_i
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BURST,
        ST_DONE
    } state_e;

    state_e                            state_q;
    logic [$clog2(BEATS_PER_LINE)-1:0] beat_q;
    cache_line_u                       line_q;
    logic                              in_burst;

    assign in_burst = (state_q == ST_BURST);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    beat_q <= '0;
                    if (req_i.read || req_i.write) begin
                        state_q <= ST_BURST;
                    end
                end
                ST_BURST: begin
                    if (bmem_resp_i) begin
                        beat_q <= beat_q + 1'b1;
                        if (&beat_q) begin
                            state_q <= ST_DONE;   // last beat
                        end
                    end
                end
                ST_DONE: state_q <= ST_IDLE;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // read beats land lowest first
    always_ff @(posedge clk) begin
        if (in_burst && bmem_resp_i && req_i.read) begin
            line_q.beats[beat_q] <= bmem_rdata_i;
        end
    end

    assign bmem_address_o = req_i.addr;
    assign bmem_read_o    = in_burst && req_i.read;
    assign bmem_write_o   = in_burst && req_i.write;
    assign bmem_wdata_o   = req_i.wdata.beats[beat_q];

    assign rsp_o.rdata = line_q;
    assign rsp_o.resp  = (state_q == ST_DONE);

endmodule : cacheline_adaptor

// ==== hdl/line_arbiter.sv ====
module line_arbiter
    import cache_cfg_pkg::*;
    import mem_types_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  line_req_t ireq_i,
    output line_rsp_t irsp_o,
    input  line_req_t dreq_i,
    output line_rsp_t drsp_o,
    output line_req_t areq_o,
    input  line_rsp_t arsp_i
);

    typedef enum logic {
        GNT_ICACHE,
        GNT_DCACHE
    } grant_e;

    grant_e grant_q;
    logic   busy_q;     // a line transfer is in flight
    logic   i_active;
    logic   d_active;
    logic   sel_d;

    assign i_active = ireq_i.read || ireq_i.write;
    assign d_active = dreq_i.read || dreq_i.write;

    // idle: pass through at once, data side first
    assign sel_d = busy_q ? (grant_q == GNT_DCACHE) : d_active;

    assign areq_o = sel_d ? dreq_i : ireq_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q  <= 1'b0;
            grant_q <= GNT_ICACHE;
        end else if (arsp_i.resp) begin
            busy_q <= 1'b0;     // released after the single resp cycle
        end else if (!busy_q && (d_active || i_active)) begin
            busy_q  <= 1'b1;
            grant_q <= sel_d ? GNT_DCACHE : GNT_ICACHE;
        end
    end

    always_comb begin
        irsp_o.rdata = arsp_i.rdata;
        drsp_o.rdata = arsp_i.rdata;
        irsp_o.resp  = arsp_i.resp && !sel_d;
        drsp_o.resp  = arsp_i.resp && sel_d;   // loser just keeps waiting
    end

endmodule : line_arbiter

// ==== hdl/mem_hier_top.sv ====
module mem_hier_top
    import cache_cfg_pkg::*;
    import mem_types_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  word_req_t         imem_req_i,
    output word_rsp_t         imem_rsp_o,
    input  word_req_t         dmem_req_i,
    output word_rsp_t         dmem_rsp_o,
    output logic [ADDR_W-1:0] bmem_address_o,
    output logic              bmem_read_o,
    output logic              bmem_write_o,
    output logic [BEAT_W-1:0] bmem_wdata_o,
    input  logic [BEAT_W-1:0] bmem_rdata_i,
    input  logic              bmem_resp_i
);

    line_req_t ireq;    // icache -> arbiter
    line_rsp_t irsp;
    line_req_t dreq;    // dcache -> arbiter
    line_rsp_t drsp;
    line_req_t areq;    // arbiter -> adaptor
    line_rsp_t arsp;

    icache icache_i (
        .clk        (clk),
        .rst        (rst),
        .req_i      (imem_req_i),
        .rsp_o      (imem_rsp_o),
        .line_req_o (ireq),
        .line_rsp_i (irsp)
    );

    dcache dcache_i (
        .clk        (clk),
        .rst        (rst),
        .req_i      (dmem_req_i),
        .rsp_o      (dmem_rsp_o),
        .line_req_o (dreq),
        .line_rsp_i (drsp)
    );

    line_arbiter line_arbiter_i (
        .clk    (clk),
        .rst    (rst),
        .ireq_i (ireq),
        .irsp_o (irsp),
        .dreq_i (dreq),
        .drsp_o (drsp),
        .areq_o (areq),
        .arsp_i (arsp)
    );

    cacheline_adaptor cacheline_adaptor_i (
        .clk            (clk),
        .rst            (rst),
        .req_i          (areq),
        .rsp_o          (arsp),
        .bmem_address_o (bmem_address_o),
        .bmem_read_o    (bmem_read_o),
        .bmem_write_o   (bmem_write_o),
        .bmem_wdata_o   (bmem_wdata_o),
        .bmem_rdata_i   (bmem_rdata_i),
        .bmem_resp_i    (bmem_resp_i)
    );

endmodule : mem_hier_top

// ==== icache/icache.sv ====
module icache
    import cache_cfg_pkg::*;
    import mem_types_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  word_req_t req_i,
    output word_rsp_t rsp_o,
    output line_req_t line_req_o,
    input  line_rsp_t line_rsp_i
);

    typedef enum logic {
        ST_COMPARE,
        ST_FILL
    } state_e;

    state_e state_q;

    logic [TAG_W-1:0]    tag_arr [NUM_SETS];
    cache_line_u         data_arr [NUM_SETS];
    logic [NUM_SETS-1:0] valid_q;

    addr_fields_t          fields;
    logic [WORD_SEL_W-1:0] word_sel;
    logic                  hit;
    logic                  req_new;
    logic                  resp_q;
    logic [WORD_W-1:0]     rdata_q;

    assign fields   = addr_fields_t'(req_i.addr);
    assign word_sel = fields.offset[OFFSET_W-1 -: WORD_SEL_W];   // drop byte bits
    assign hit      = valid_q[fields.index] && (tag_arr[fields.index] == fields.tag);
    assign req_new  = req_i.read && !resp_q;   // held request already answered

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_COMPARE;
            valid_q <= '0;
            resp_q  <= 1'b0;
        end else begin
            resp_q <= 1'b0;
            case (state_q)
                ST_COMPARE: begin
                    if (req_new && hit) begin
                        resp_q <= 1'b1;
                    end else if (req_new) begin
                        state_q <= ST_FILL;
                    end
                end
                ST_FILL: begin
                    if (line_rsp_i.resp) begin
                        valid_q[fields.index] <= 1'b1;
                        state_q <= ST_COMPARE;   // replay as a hit
                    end
                end
                default: state_q <= ST_COMPARE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_FILL && line_rsp_i.resp) begin
            tag_arr[fields.index]  <= fields.tag;
            data_arr[fields.index] <= line_rsp_i.rdata;
        end
        if (state_q == ST_COMPARE && hit) begin
            rdata_q <= data_arr[fields.index].words[word_sel];
        end
    end

    assign rsp_o.rdata = rdata_q;
    assign rsp_o.resp  = resp_q;

    always_comb begin
        line_req_o.addr  = {fields.tag, fields.index, {OFFSET_W{1'b0}}};
        line_req_o.read  = (state_q == ST_FILL);
        line_req_o.write = 1'b0;                 // read only
        line_req_o.wdata = '0;
    end

endmodule : icache

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module mem_hier_tb -f sources.f

./obj_dir/Vmem_hier_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation finished: PASS$" sim.log; then
    echo "run.sh: test passed"
else
    echo "run.sh: test failed"
    exit 1
fi

// ==== sources.f ====
common/cache_cfg_pkg.sv
common/mem_types_pkg.sv
icache/icache.sv
dcache/dcache.sv
hdl/line_arbiter.sv
hdl/cacheline_adaptor.sv
hdl/mem_hier_top.sv
tb/burst_mem_model.sv
tb/mem_hier_tb.sv

// ==== tb/burst_mem_model.sv ====
module burst_mem_model
    import cache_cfg_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [ADDR_W-1:0] address_i,
    input  logic              read_i,
    input  logic              write_i,
    input  logic [BEAT_W-1:0] wdata_i,
    output logic [BEAT_W-1:0] rdata_o,
    output logic              resp_o
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] FILL_XOR = 32'h5a5a_0000;

    logic [BEAT_W-1:0] mem [logic [28:0]];     // sparse, keyed by beat address
    logic [BEAT_W-1:0] rdata_q = '0;
    logic              resp_q = 1'b0;
    logic [2:0]        sent;                   // beats answered in this burst
    logic [1:0]        gap;                    // idle cycles before the next beat
    logic [28:0]       beat_key;

    // untouched words read as their own address xor a fixed pattern
    function automatic logic [BEAT_W-1:0] beat_at(input logic [28:0] key);
        if (mem.exists(key)) begin
            return mem[key];
        end
        return {{key, 3'b100} ^ FILL_XOR, {key, 3'b000} ^ FILL_XOR};
    endfunction

    function automatic logic [31:0] peek_word(input logic [31:0] addr);
        logic [BEAT_W-1:0] beat;
        beat = beat_at(addr[31:3]);
        return addr[2] ? beat[63:32] : beat[31:0];
    endfunction

    assign beat_key = address_i[31:3] + 29'(sent);

    always @(posedge clk) begin
        if (rst) begin
            resp_q <= 1'b0;
            sent   <= '0;
            gap    <= '0;
        end else begin
            resp_q <= 1'b0;
            if (!(read_i || write_i)) begin
                sent <= '0;
                gap  <= 2'($urandom_range(3, 0));
            end else begin
                if (resp_q && write_i) begin
                    mem[beat_key - 29'd1] = wdata_i;   // beat of the resp now high
                end
                if (sent < 3'd4 && gap == 2'd0) begin
                    resp_q  <= 1'b1;
                    rdata_q <= beat_at(beat_key);
                    sent    <= sent + 3'd1;
                    gap     <= 2'($urandom_range(3, 0));
                end else if (gap != 2'd0) begin
                    gap <= gap - 2'd1;
                end
            end
        end
    end

    assign rdata_o = rdata_q;
    assign resp_o  = resp_q;

endmodule : burst_mem_model

// ==== tb/mem_hier_tb.sv ====
module mem_hier_tb
    import cache_cfg_pkg::*;
    import mem_types_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          TIMEOUT_CYCLES = 400;
    localparam logic [31:0] FILL_XOR       = 32'h5a5a_0000;

    logic              clk;
    logic              rst;
    word_req_t         imem_req;
    word_rsp_t         imem_rsp;
    word_req_t         dmem_req;
    word_rsp_t         dmem_rsp;
    logic [ADDR_W-1:0] bmem_address;
    logic              bmem_read;
    logic              bmem_write;
    logic [BEAT_W-1:0] bmem_wdata;
    logic [BEAT_W-1:0] bmem_rdata;
    logic              bmem_resp;

    logic [31:0] shadow [logic [31:0]];     // expected memory by word address
    logic [31:0] i_exp, d_exp;
    logic [31:0] i_rdata, d_rdata;
    logic        d_load;                    // outstanding data access is a load
    logic        req_made;
    logic        hit_probe;                 // fetch must hit in one cycle
    logic [31:0] wb_line;
    logic [63:0] wb_exp;
    logic [1:0]  wb_idx;
    int          wb_total;
    logic        tie_armed, tie_done;
    logic [31:0] tie_dline;
    int          assert_errs = 0;
    int          check_errs, timeouts;

    mem_hier_top mem_hier_top_i (
        .clk            (clk),
        .rst            (rst),
        .imem_req_i     (imem_req),
        .imem_rsp_o     (imem_rsp),
        .dmem_req_i     (dmem_req),
        .dmem_rsp_o     (dmem_rsp),
        .bmem_address_o (bmem_address),
        .bmem_read_o    (bmem_read),
        .bmem_write_o   (bmem_write),
        .bmem_wdata_o   (bmem_wdata),
        .bmem_rdata_i   (bmem_rdata),
        .bmem_resp_i    (bmem_resp)
    );

    burst_mem_model burst_mem_model_i (
        .clk       (clk),
        .rst       (rst),
        .address_i (bmem_address),
        .read_i    (bmem_read),
        .write_i   (bmem_write),
        .wdata_i   (bmem_wdata),
        .rdata_o   (bmem_rdata),
        .resp_o    (bmem_resp)
    );

    assign i_rdata = imem_rsp.rdata;
    assign d_rdata = dmem_rsp.rdata;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] shadow_word(input logic [31:0] addr);
        logic [31:0] a;
        a = {addr[31:2], 2'b00};
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return a ^ FILL_XOR;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            wb_idx   <= '0;
            wb_total <= 0;
            tie_done <= 1'b0;
        end else begin
            if (bmem_write && bmem_resp) begin
                wb_idx   <= wb_idx + 2'd1;
                wb_total <= wb_total + 1;
            end
            if (tie_armed && bmem_read) begin
                tie_done <= 1'b1;
            end
        end
    end

    // next victim beat as the shadow sees it
    always @(negedge clk) begin
        wb_exp <= {shadow_word(wb_line + {27'd0, wb_idx, 3'b100}),
                   shadow_word(wb_line + {27'd0, wb_idx, 3'b000})};
    end

    idle_after_reset: assert property (@(posedge clk) disable iff (rst)
        !req_made |-> !bmem_read && !bmem_write && !imem_rsp.resp && !dmem_rsp.resp)
    else begin
        assert_errs = assert_errs + 1;
        $display("ERR %0t: memory or response activity before any request", $time);
    end

    fetch_data: assert property (@(posedge clk) disable iff (rst)
        imem_rsp.resp |-> i_rdata == i_exp)
    else begin
        assert_errs = assert_errs + 1;
        $display("ERR %0t: fetch returned %h, expected %h", $time, $sampled(i_rdata), i_exp);
    end

    fetch_hit_latency: assert property (@(posedge clk) disable iff (rst)
        hit_probe |=> imem_rsp.resp)
    else begin
        assert_errs = assert_errs + 1;
        $display("ERR %0t: fetch hit not answered in one cycle", $time);
    end

    load_data: assert property (@(posedge clk) disable iff (rst)
        dmem_rsp.resp && d_load |-> d_rdata == d_exp)
    else begin
        assert_errs = assert_errs + 1;
        $display("ERR %0t: load returned %h, expected %h", $time, $sampled(d_rdata), d_exp);
    end

    victim_beats: assert property (@(posedge clk) disable iff (rst)
        bmem_write && bmem_resp |-> bmem_address == wb_line && bmem_wdata == wb_exp)
    else begin
        assert_errs = assert_errs + 1;
        $display("ERR %0t: write beat %h at %h, expected %h at %h", $time,
                 $sampled(bmem_wdata), $sampled(bmem_address), wb_exp, wb_line);
    end

    data_wins_tie: assert property (@(posedge clk) disable iff (rst)
        tie_armed && !tie_done && bmem_read |-> bmem_address == tie_dline)
    else begin
        assert_errs = assert_errs + 1;
        $display("ERR %0t: first line read at %h, expected data line %h", $time,
                 $sampled(bmem_address), tie_dline);
    end

    // drops each request in its resp cycle
    task automatic wait_resp(input logic want_i, input logic want_d, input string what);
        logic got_i;
        logic got_d;
        int   n;
        got_i = !want_i;
        got_d = !want_d;
        for (n = 0; n < TIMEOUT_CYCLES && !(got_i && got_d); n++) begin
            @(negedge clk);
            hit_probe = 1'b0;
            if (imem_rsp.resp) begin
                got_i = 1'b1;
                imem_req.read = 1'b0;
            end
            if (dmem_rsp.resp) begin
                got_d = 1'b1;
                dmem_req.read  = 1'b0;
                dmem_req.write = 1'b0;
            end
        end
        if (!(got_i && got_d)) begin
            timeouts = timeouts + 1;
            $display("%s got no response within %0d cycles", what, TIMEOUT_CYCLES);
            imem_req = '0;
            dmem_req = '0;
        end
    endtask

    task automatic fetch(input logic [31:0] addr, input logic expect_hit);
        @(negedge clk);
        req_made      = 1'b1;
        i_exp         = shadow_word(addr);
        hit_probe     = expect_hit;
        imem_req.addr = addr;
        imem_req.read = 1'b1;
        wait_resp(1'b1, 1'b0, "instruction fetch");
    endtask

    task automatic data_access(input logic [31:0] addr, input logic is_store,
                               input logic [3:0] mask, input logic [31:0] data);
        logic [31:0] merged;
        int          b;
        @(negedge clk);
        req_made = 1'b1;
        merged   = shadow_word(addr);
        if (is_store) begin
            for (b = 0; b < 4; b++) begin
                if (mask[b]) begin
                    merged[8*b +: 8] = data[8*b +: 8];
                end
            end
            shadow[{addr[31:2], 2'b00}] = merged;
        end
        d_exp          = merged;
        d_load         = !is_store;
        dmem_req.addr  = addr;
        dmem_req.read  = !is_store;
        dmem_req.write = is_store;
        dmem_req.wmask = mask;
        dmem_req.wdata = data;
        wait_resp(1'b0, 1'b1, is_store ? "data store" : "data load");
    endtask

    initial begin
        logic [31:0] ia, a3, a4, ib, db, mem_word;
        void'($urandom(32'hbd03_c3c5));
        rst        = 1'b1;
        imem_req   = '0;
        dmem_req   = '0;
        req_made   = 1'b0;
        hit_probe  = 1'b0;
        d_load     = 1'b0;
        i_exp      = '0;
        d_exp      = '0;
        wb_line    = '0;
        tie_armed  = 1'b0;
        tie_dline  = '0;
        check_errs = 0;
        timeouts   = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (5) @(negedge clk);   // quiet window after reset

        ia = $urandom & 32'hffff_fe1c;                       // icache set 0
        fetch(ia, 1'b0);
        fetch({ia[31:5], 5'b0} | ($urandom & 32'h1c), 1'b1);

        a3 = ($urandom & 32'hffff_fe1c) | 32'h40;            // dcache set 2
        data_access(a3, 1'b1, 4'($urandom_range(14, 1)), $urandom);
        data_access(a3, 1'b0, 4'h0, 32'h0);

        a4 = ($urandom & 32'hffff_fe1c) | 32'h60;            // dcache set 3
        wb_line = {a4[31:5], 5'b0};
        data_access(a4, 1'b1, 4'hf, $urandom);
        data_access(a4 + 32'd512, 1'b0, 4'h0, 32'h0);   // same set so a4 gets evicted
        assert (wb_total == 4) else begin
            check_errs = check_errs + 1;
            $display("ERR %0t: %0d victim beats written, expected 4", $time, wb_total);
        end
        data_access(a4, 1'b0, 4'h0, 32'h0);
        mem_word = burst_mem_model_i.peek_word(a4);
        assert (mem_word == shadow_word(a4)) else begin
            check_errs = check_errs + 1;
            $display("ERR %0t: memory holds %h at %h, expected %h", $time,
                     mem_word, a4, shadow_word(a4));
        end

        ib = ($urandom & 32'hffff_fe1c) | 32'he0;            // icache set 7
        db = ($urandom & 32'hffff_fe1c) | 32'hc0;            // dcache set 6
        @(negedge clk);
        tie_dline      = {db[31:5], 5'b0};
        tie_armed      = 1'b1;
        i_exp          = shadow_word(ib);
        d_exp          = shadow_word(db);
        d_load         = 1'b1;
        imem_req.addr  = ib;
        imem_req.read  = 1'b1;
        dmem_req.addr  = db;
        dmem_req.read  = 1'b1;
        dmem_req.write = 1'b0;
        wait_resp(1'b1, 1'b1, "simultaneous fetch and load");

        repeat (3) @(negedge clk);
        $display("assertion errors: %0d, check errors: %0d, timeouts: %0d",
                 assert_errs, check_errs, timeouts);
        if (assert_errs == 0 && check_errs == 0 && timeouts == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule : mem_hier_tb
